// ==== include/cpu_consts.svh ====
// processor constants
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define CPU_XLEN        32
`define CPU_NREG        32
`define CPU_IMEM_DEPTH  256
`define CPU_IMEM_AW     8

// opcodes, instruction bits 31:26
`define OP_RTYPE  6'h00
`define OP_ADDI   6'h01
`define OP_LW     6'h02
`define OP_SW     6'h03
`define OP_BEQ    6'h04
`define OP_HALT   6'h3f

// function codes for OP_RTYPE
`define FN_ADD    11'h000
`define FN_SUB    11'h001
`define FN_AND    11'h002
`define FN_OR     11'h003

`endif

// ==== verilog/cpu_pkg.sv ====
// processor types
`include "cpu_consts.svh"

package cpu_pkg;

    typedef logic [$clog2(`CPU_NREG)-1:0] reg_t;
    typedef logic [5:0] op_t;
    typedef logic [10:0] funct_t;

    // register form: op rd rs0 rs1 funct
    typedef struct packed {
        op_t    op;
        reg_t   rd;
        reg_t   rs0;
        reg_t   rs1;
        funct_t funct;
    } r_form_t;

    // immediate form, rd is a source for sw and beq
    typedef struct packed {
        op_t               op;
        reg_t              rd;
        reg_t              rs0;
        logic signed [15:0] imm;
    } i_form_t;

    typedef union packed {
        r_form_t r;
        i_form_t i;
    } instr_u;

    // decoded instruction, all zero is a bubble
    typedef struct packed {
        logic                 valid;
        op_t                  op;
        funct_t               funct;
        reg_t                 rd;
        logic                 regwrite;
        logic                 memread;
        logic                 memwrite;
        logic                 branch;
        logic                 halt;
        logic [`CPU_XLEN-1:0] imm;
        logic [`CPU_XLEN-1:0] pc;
    } inst_t;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EXE,
        FWD_MEM
    } fwd_e;

endpackage

// ==== verilog/hazard_if.sv ====
// hazard signal bundle
`timescale 1ns/1ns

interface hazard_if (
    input logic clk
);
    // decode sources
    cpu_pkg::reg_t rs0;
    cpu_pkg::reg_t rs1;
    // execute destination
    cpu_pkg::reg_t rd_e;
    logic          regwrite_e;
    logic          memread_e;
    // memory destination
    cpu_pkg::reg_t rd_m;
    logic          regwrite_m;
    // hazard unit results
    cpu_pkg::fwd_e forward0;
    cpu_pkg::fwd_e forward1;
    logic          lwstall;

    modport dec (output rs0, rs1, input forward0, forward1);
    modport exe (input clk, output rd_e, regwrite_e, memread_e);
    modport mem (input clk, output rd_m, regwrite_m);
    modport haz (input rs0, rs1, rd_e, regwrite_e, memread_e, rd_m, regwrite_m,
                 output forward0, forward1, lwstall);

endinterface

// ==== verilog/fetch.sv ====
// instruction fetch
`timescale 1ns/1ns
`include "cpu_consts.svh"

module fetch (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    enable,
    input  logic                    branch_taken,
    input  logic [`CPU_XLEN-1:0]    branch_target,
    input  logic                    imem_we,
    input  logic [`CPU_IMEM_AW-1:0] imem_addr,
    input  logic [`CPU_XLEN-1:0]    imem_wdata,
    output logic [`CPU_XLEN-1:0]    pc,
    output logic [`CPU_XLEN-1:0]    instr
);

    logic [`CPU_XLEN-1:0] imem [0:`CPU_IMEM_DEPTH-1];
    logic [`CPU_XLEN-1:0] pc_next;

    always_comb begin
        if (branch_taken)
            pc_next = branch_target;
        else if (enable)
            pc_next = pc + `CPU_XLEN'd4;
        else
            pc_next = pc;
    end

    always_ff @(posedge clk) begin
        if (!rstn)
            pc <= '0;
        else
            pc <= pc_next;
    end

    // read ahead with the next pc so instr always matches pc
    always_ff @(posedge clk) begin
        if (imem_we)
            imem[imem_addr] <= imem_wdata;
        instr <= imem[pc_next[`CPU_IMEM_AW+1:2]];
    end

endmodule

// ==== verilog/register_file.sv ====
// integer register file
`timescale 1ns/1ns
`include "cpu_consts.svh"

module register_file (
    input  logic                 clk,
    input  logic                 rstn,
    input  cpu_pkg::reg_t        raddr0,
    input  cpu_pkg::reg_t        raddr1,
    output logic [`CPU_XLEN-1:0] rdata0,
    output logic [`CPU_XLEN-1:0] rdata1,
    input  logic                 we,
    input  cpu_pkg::reg_t        waddr,
    input  logic [`CPU_XLEN-1:0] wdata
);

    logic [`CPU_XLEN-1:0] regs [0:`CPU_NREG-1];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `CPU_NREG; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads zero
    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

    a_waddr_known: assert property (@(posedge clk) disable iff (!rstn)
        we |-> !$isunknown(waddr));

endmodule

// ==== verilog/decode.sv ====
// instruction decode
`timescale 1ns/1ns
`include "cpu_consts.svh"

module decode (
    input  logic [`CPU_XLEN-1:0] pc,
    input  cpu_pkg::instr_u      instr,
    hazard_if.dec                hif,
    input  logic [`CPU_XLEN-1:0] rf_rdata0,
    input  logic [`CPU_XLEN-1:0] rf_rdata1,
    input  logic [`CPU_XLEN-1:0] result_e,
    input  logic [`CPU_XLEN-1:0] result_m,
    output cpu_pkg::inst_t       inst,
    output logic [`CPU_XLEN-1:0] op0,
    output logic [`CPU_XLEN-1:0] op1
);

    function automatic logic [`CPU_XLEN-1:0] fwd_mux(
        input cpu_pkg::fwd_e        sel,
        input logic [`CPU_XLEN-1:0] rf,
        input logic [`CPU_XLEN-1:0] e,
        input logic [`CPU_XLEN-1:0] m
    );
        case (sel)
            cpu_pkg::FWD_EXE: return e;
            cpu_pkg::FWD_MEM: return m;
            default:          return rf;
        endcase
    endfunction

    always_comb begin
        inst          = '0;
        // an all-zero word is a bubble
        inst.valid    = |instr;
        inst.op       = instr.r.op;
        inst.funct    = `FN_ADD;
        inst.rd       = instr.r.rd;
        inst.imm      = {{(`CPU_XLEN-16){instr.i.imm[15]}}, instr.i.imm};
        inst.pc       = pc;
        hif.rs0       = instr.r.rs0;
        // second source only when the op reads it
        hif.rs1       = '0;
        case (instr.r.op)
            `OP_RTYPE: begin
                inst.funct    = instr.r.funct;
                inst.regwrite = 1'b1;
                hif.rs1       = instr.r.rs1;
            end
            `OP_ADDI: inst.regwrite = 1'b1;
            `OP_LW: begin
                inst.regwrite = 1'b1;
                inst.memread  = 1'b1;
            end
            `OP_SW: begin
                inst.memwrite = 1'b1;
                hif.rs1       = instr.i.rd;
            end
            `OP_BEQ: begin
                inst.branch = 1'b1;
                hif.rs1     = instr.i.rd;
            end
            `OP_HALT: begin
                inst.halt = 1'b1;
                hif.rs0   = '0;
            end
            default: inst.valid = 1'b0;
        endcase
    end

    assign op0 = fwd_mux(hif.forward0, rf_rdata0, result_e, result_m);
    assign op1 = fwd_mux(hif.forward1, rf_rdata1, result_e, result_m);

endmodule

// ==== verilog/exec.sv ====
// execute stage
`timescale 1ns/1ns
`include "cpu_consts.svh"

module exec (
    input  cpu_pkg::inst_t       inst,
    input  logic [`CPU_XLEN-1:0] op0,
    input  logic [`CPU_XLEN-1:0] op1,
    hazard_if.exe                hif,
    output cpu_pkg::inst_t       inst_out,
    output logic [`CPU_XLEN-1:0] result,
    output logic [`CPU_XLEN-1:0] store_data,
    output logic                 branch_taken,
    output logic [`CPU_XLEN-1:0] branch_target
);

    logic [`CPU_XLEN-1:0] opb;

    // immediate for addi and address generation
    assign opb = (inst.op == `OP_RTYPE) ? op1 : inst.imm;

    always_comb begin
        case (inst.funct)
            `FN_SUB: result = op0 - opb;
            `FN_AND: result = op0 & opb;
            `FN_OR:  result = op0 | opb;
            default: result = op0 + opb;
        endcase
    end

    assign store_data = op1;
    assign inst_out   = inst;

    // beq offset counts words from pc + 4
    assign branch_taken  = inst.valid && inst.branch && (op0 == op1);
    assign branch_target = inst.pc + `CPU_XLEN'd4 + {inst.imm[`CPU_XLEN-3:0], 2'b00};

    assign hif.rd_e       = inst.rd;
    assign hif.regwrite_e = inst.valid && inst.regwrite;
    assign hif.memread_e  = inst.valid && inst.memread;

    a_branch_valid: assert property (@(posedge hif.clk)
        branch_taken |-> inst.valid && inst.op == `OP_BEQ);

endmodule

// ==== verilog/memory.sv ====
// data memory stage
`timescale 1ns/1ns
`include "cpu_consts.svh"

module memory (
    input  cpu_pkg::inst_t       inst,
    input  logic [`CPU_XLEN-1:0] result,
    input  logic [`CPU_XLEN-1:0] store_data,
    hazard_if.mem                hif,
    output logic [`CPU_XLEN-1:0] dmem_addr,
    output logic [`CPU_XLEN-1:0] dmem_wdata,
    output logic                 dmem_re,
    output logic                 dmem_we,
    input  logic [`CPU_XLEN-1:0] dmem_rdata,
    input  logic                 miss,
    output logic                 stall,
    output cpu_pkg::inst_t       inst_out,
    output logic [`CPU_XLEN-1:0] wb_data
);

    // port held stable by the stage register while stalled
    assign dmem_addr  = result;
    assign dmem_wdata = store_data;
    assign dmem_re    = inst.valid && inst.memread;
    assign dmem_we    = inst.valid && inst.memwrite;

    assign stall    = (dmem_re || dmem_we) && miss;
    assign inst_out = inst;
    assign wb_data  = inst.memread ? dmem_rdata : result;

    assign hif.rd_m       = inst.rd;
    assign hif.regwrite_m = inst.valid && inst.regwrite;

    a_re_we_excl: assert property (@(posedge hif.clk) dmem_re |-> !dmem_we);

endmodule

// ==== verilog/hazard_unit.sv ====
// forwarding and load-use detection
`timescale 1ns/1ns

module hazard_unit (
    hazard_if.haz hif
);

    // execute stage wins over memory stage
    function automatic cpu_pkg::fwd_e pick_src(input cpu_pkg::reg_t rs);
        if (rs == '0)
            return cpu_pkg::FWD_RF;
        if (hif.regwrite_e && hif.rd_e == rs)
            return cpu_pkg::FWD_EXE;
        if (hif.regwrite_m && hif.rd_m == rs)
            return cpu_pkg::FWD_MEM;
        return cpu_pkg::FWD_RF;
    endfunction

    assign hif.forward0 = pick_src(hif.rs0);
    assign hif.forward1 = pick_src(hif.rs1);

    // load result not ready until the memory stage
    assign hif.lwstall = hif.memread_e && hif.rd_e != '0 &&
                         (hif.rd_e == hif.rs0 || hif.rd_e == hif.rs1);

endmodule

// ==== verilog/cpu.sv ====
// five-stage pipeline top level
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    run,
    input  logic                    imem_we,
    input  logic [`CPU_IMEM_AW-1:0] imem_addr,
    input  logic [`CPU_XLEN-1:0]    imem_wdata,
    output logic [`CPU_XLEN-1:0]    dmem_addr,
    output logic [`CPU_XLEN-1:0]    dmem_wdata,
    output logic                    dmem_re,
    output logic                    dmem_we,
    input  logic [`CPU_XLEN-1:0]    dmem_rdata,
    input  logic                    miss,
    output logic                    halted
);

    logic adv, front_en, take_br, mem_stall, branch_taken;
    logic [`CPU_XLEN-1:0] pc_f, instr_f, pc_d, instr_d, branch_target;
    logic [`CPU_XLEN-1:0] rf_rdata0, rf_rdata1, op0_d, op1_d, op0_e, op1_e;
    logic [`CPU_XLEN-1:0] alu_e, sdata_e, alu_m, sdata_m, wb_data;
    cpu_pkg::inst_t inst_d, inst_e, inst_xo, inst_m, inst_mo, inst_w;

    hazard_if hif (.clk(clk));

    ////////////////////////////////////////////////////////////////////////////
    // stall and flush control

    assign adv      = run && !halted && !mem_stall;
    assign front_en = adv && !hif.lwstall && !branch_taken;
    assign take_br  = adv && branch_taken;
    assign halted   = inst_w.valid && inst_w.halt;

    ////////////////////////////////////////////////////////////////////////////
    // stages and pipeline registers

    fetch u_fetch (.clk(clk), .rstn(rstn), .enable(front_en), .branch_taken(take_br),
        .branch_target(branch_target), .imem_we(imem_we), .imem_addr(imem_addr),
        .imem_wdata(imem_wdata), .pc(pc_f), .instr(instr_f));

    always_ff @(posedge clk) begin
        if (!rstn || take_br) begin
            pc_d    <= '0;
            instr_d <= '0;
        end else if (front_en) begin
            pc_d    <= pc_f;
            instr_d <= instr_f;
        end
    end

    decode u_decode (.pc(pc_d), .instr(instr_d), .hif(hif), .rf_rdata0(rf_rdata0),
        .rf_rdata1(rf_rdata1), .result_e(alu_e), .result_m(wb_data), .inst(inst_d),
        .op0(op0_d), .op1(op1_d));

    // writes at the edge that loads the writeback register
    register_file u_rf (.clk(clk), .rstn(rstn), .raddr0(hif.rs0), .raddr1(hif.rs1),
        .rdata0(rf_rdata0), .rdata1(rf_rdata1),
        .we(adv && inst_mo.valid && inst_mo.regwrite), .waddr(inst_mo.rd), .wdata(wb_data));

    // bubble on load-use or taken branch
    always_ff @(posedge clk) begin
        if (!rstn || (adv && (hif.lwstall || branch_taken)))
            inst_e <= '0;
        else if (front_en)
            inst_e <= inst_d;
    end

    always_ff @(posedge clk) begin
        if (front_en) begin
            op0_e <= op0_d;
            op1_e <= op1_d;
        end
    end

    exec u_exec (.inst(inst_e), .op0(op0_e), .op1(op1_e), .hif(hif), .inst_out(inst_xo),
        .result(alu_e), .store_data(sdata_e), .branch_taken(branch_taken),
        .branch_target(branch_target));

    // nothing behind a halt reaches the memory port
    always_ff @(posedge clk) begin
        if (!rstn)
            inst_m <= '0;
        else if (adv)
            inst_m <= inst_m.halt ? '0 : inst_xo;
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            alu_m   <= alu_e;
            sdata_m <= sdata_e;
        end
    end

    memory u_memory (.inst(inst_m), .result(alu_m), .store_data(sdata_m), .hif(hif),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_re(dmem_re),
        .dmem_we(dmem_we), .dmem_rdata(dmem_rdata), .miss(miss), .stall(mem_stall),
        .inst_out(inst_mo), .wb_data(wb_data));

    always_ff @(posedge clk) begin
        if (!rstn)
            inst_w <= '0;
        else if (adv)
            inst_w <= inst_mo;
    end

    hazard_unit u_hazard (.hif(hif));

endmodule

// ==== verification/cpu_tb.sv ====
// pipelined processor testbench
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_tb;

    logic                    clk;
    logic                    rstn;
    logic                    run;
    logic                    imem_we;
    logic [`CPU_IMEM_AW-1:0] imem_addr;
    logic [`CPU_XLEN-1:0]    imem_wdata;
    logic [`CPU_XLEN-1:0]    dmem_addr;
    logic [`CPU_XLEN-1:0]    dmem_wdata;
    logic                    dmem_re;
    logic                    dmem_we;
    logic [`CPU_XLEN-1:0]    dmem_rdata;
    logic                    miss;
    logic                    halted;

    // program store, one slice per test
    logic [`CPU_XLEN-1:0] prog [0:127];
    int                   prog_n;
    int                   test_start [0:3];
    int                   test_len [0:3];

    // data memory model and reference state
    logic [`CPU_XLEN-1:0] dmem [0:255];
    logic [`CPU_XLEN-1:0] ref_mem [0:255];
    logic [`CPU_XLEN-1:0] ref_regs [0:`CPU_NREG-1];

    // expected and observed stores
    logic [`CPU_XLEN-1:0] exp_addr [0:63];
    logic [`CPU_XLEN-1:0] exp_data [0:63];
    logic [`CPU_XLEN-1:0] act_addr [0:63];
    logic [`CPU_XLEN-1:0] act_data [0:63];
    int                   exp_n;
    int                   act_n;

    logic        rand_miss;
    logic [31:0] rnd_state;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          run_cycles;
    int          cycle_limit;

    cpu dut0 (
        .clk(clk), .rstn(rstn), .run(run), .imem_we(imem_we), .imem_addr(imem_addr),
        .imem_wdata(imem_wdata), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_re(dmem_re), .dmem_we(dmem_we), .dmem_rdata(dmem_rdata), .miss(miss),
        .halted(halted)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // initial data memory contents
    function automatic logic [`CPU_XLEN-1:0] fill_word(input int idx);
        return 32'h9e37_79b9 * (idx + 1);
    endfunction

    function automatic logic [31:0] enc_r(input logic [10:0] fn, input logic [4:0] rd,
                                          input logic [4:0] rs0, input logic [4:0] rs1);
        return {`OP_RTYPE, rd, rs0, rs1, fn};
    endfunction

    // for sw and beq rd is the second source
    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rd,
                                          input logic [4:0] rs0, input logic [15:0] imm);
        return {op, rd, rs0, imm};
    endfunction

    task emit(input logic [31:0] w);
        prog[prog_n] = w;
        prog_n++;
    endtask

    task build_programs();
        prog_n = 0;
        // dependent alu chain
        test_start[0] = prog_n;
        emit(enc_i(`OP_ADDI, 1, 0, 16'h1234));
        emit(enc_i(`OP_ADDI, 2, 1, 16'hff00));
        emit(enc_r(`FN_ADD, 3, 1, 2));
        emit(enc_r(`FN_SUB, 4, 3, 1));
        emit(enc_r(`FN_AND, 5, 4, 3));
        emit(enc_r(`FN_OR, 6, 5, 2));
        emit(enc_i(`OP_ADDI, 7, 6, -16'sd3));
        emit(enc_i(`OP_SW, 3, 0, 16'd0));
        emit(enc_i(`OP_SW, 4, 0, 16'd4));
        emit(enc_i(`OP_SW, 5, 0, 16'd8));
        emit(enc_i(`OP_SW, 6, 0, 16'd12));
        emit(enc_i(`OP_SW, 7, 0, 16'd16));
        emit({`OP_HALT, 26'd0});
        test_len[0] = prog_n - test_start[0];
        // store, load, dependent use
        test_start[1] = prog_n;
        emit(enc_i(`OP_ADDI, 1, 0, 16'd100));
        emit(enc_i(`OP_ADDI, 2, 0, 16'h0040));
        emit(enc_i(`OP_SW, 1, 2, 16'd0));
        emit(enc_i(`OP_LW, 3, 2, 16'd0));
        emit(enc_r(`FN_ADD, 4, 3, 1));
        emit(enc_i(`OP_SW, 4, 2, 16'd4));
        emit(enc_i(`OP_LW, 5, 2, 16'd8));
        emit(enc_i(`OP_ADDI, 6, 5, 16'd1));
        emit(enc_i(`OP_SW, 6, 2, 16'd12));
        emit({`OP_HALT, 26'd0});
        test_len[1] = prog_n - test_start[1];
        // taken then not-taken beq
        test_start[2] = prog_n;
        emit(enc_i(`OP_ADDI, 1, 0, 16'd3));
        emit(enc_i(`OP_ADDI, 2, 0, 16'd3));
        emit(enc_i(`OP_BEQ, 2, 1, 16'd2));
        emit(enc_i(`OP_SW, 1, 0, 16'd0));
        emit(enc_i(`OP_SW, 2, 0, 16'd4));
        emit(enc_i(`OP_SW, 1, 0, 16'd8));
        emit(enc_i(`OP_ADDI, 3, 0, 16'd4));
        emit(enc_i(`OP_BEQ, 3, 1, 16'd1));
        emit(enc_i(`OP_SW, 3, 0, 16'd12));
        emit({`OP_HALT, 26'd0});
        test_len[2] = prog_n - test_start[2];
        // r0 writes, then stores behind the halt
        test_start[3] = prog_n;
        emit(enc_i(`OP_ADDI, 0, 0, 16'd55));
        emit(enc_r(`FN_ADD, 1, 0, 0));
        emit(enc_i(`OP_ADDI, 2, 0, 16'h0020));
        emit(enc_i(`OP_SW, 0, 2, 16'd0));
        emit(enc_i(`OP_SW, 1, 2, 16'd4));
        emit(enc_r(`FN_OR, 0, 2, 2));
        emit(enc_i(`OP_SW, 0, 2, 16'd8));
        emit({`OP_HALT, 26'd0});
        emit(enc_i(`OP_SW, 2, 2, 16'd12));
        emit(enc_i(`OP_ADDI, 3, 0, 16'd1));
        emit(enc_i(`OP_SW, 3, 2, 16'd16));
        test_len[3] = prog_n - test_start[3];
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // ISA reference, fills the expected store list

    function automatic void ref_run(input int start, input int len);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [4:0]  rd;
        int          i;
        int          steps;
        logic        done;
        for (i = 0; i < `CPU_NREG; i++)
            ref_regs[i] = '0;
        for (i = 0; i < 256; i++)
            ref_mem[i] = fill_word(i);
        exp_n = 0;
        pc    = '0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 1000) begin
            w   = (pc[31:2] < len) ? prog[start + pc[31:2]] : '0;
            rd  = w[25:21];
            imm = {{16{w[15]}}, w[15:0]};
            a   = ref_regs[w[20:16]];
            pc  = pc + 4;
            case (w[31:26])
                `OP_RTYPE: begin
                    b = ref_regs[w[15:11]];
                    case (w[10:0])
                        `FN_SUB: b = a - b;
                        `FN_AND: b = a & b;
                        `FN_OR:  b = a | b;
                        default: b = a + b;
                    endcase
                    if (rd != 0)
                        ref_regs[rd] = b;
                end
                `OP_ADDI: begin
                    if (rd != 0)
                        ref_regs[rd] = a + imm;
                end
                `OP_LW: begin
                    b = a + imm;
                    if (rd != 0)
                        ref_regs[rd] = ref_mem[b[9:2]];
                end
                `OP_SW: begin
                    b = a + imm;
                    ref_mem[b[9:2]] = ref_regs[rd];
                    if (exp_n < 64) begin
                        exp_addr[exp_n] = b;
                        exp_data[exp_n] = ref_regs[rd];
                    end
                    exp_n++;
                end
                `OP_BEQ: begin
                    if (a == ref_regs[rd])
                        pc = pc + (imm << 2);
                end
                `OP_HALT: done = 1'b1;
                default: ;
            endcase
            steps++;
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checks

    task check_store(input string name, input int idx,
                     input logic [`CPU_XLEN-1:0] ea, input logic [`CPU_XLEN-1:0] ed,
                     input logic [`CPU_XLEN-1:0] aa, input logic [`CPU_XLEN-1:0] ad);
        if (aa !== ea || ad !== ed) begin
            $display("MISMATCH %s store %0d: expected %h:%h actual %h:%h",
                     name, idx, ea, ed, aa, ad);
            errors++;
        end
    endtask

    task check_level(input string name, input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s %s: expected %b actual %b", name, what, exp, act);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // memory model, store recorder, run limit

    always @(posedge clk) begin
        #1;
        if (rand_miss) begin
            rnd_state = xorshift32(rnd_state);
            miss      = rnd_state[0];
        end else begin
            miss = 1'b0;
        end
        dmem_rdata = dmem[dmem_addr[9:2]];
    end

    // a store completes in a cycle with miss low
    always @(negedge clk) begin
        if (rstn && dmem_we && !miss) begin
            if (act_n < 64) begin
                act_addr[act_n] = dmem_addr;
                act_data[act_n] = dmem_wdata;
            end
            act_n++;
            dmem[dmem_addr[9:2]] = dmem_wdata;
        end
    end

    always @(posedge clk) begin
        if (run) begin
            run_cycles++;
            if (run_cycles > cycle_limit) begin
                $display("timeout: no halt within %0d run cycles", cycle_limit);
                $display("FAIL: see errors above");
                $finish;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequencing

    task reset_dut();
        @(posedge clk);
        #1;
        rstn = 1'b0;
        run  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
    endtask

    task automatic load_program(input int start, input int len);
        int i;
        for (i = 0; i < `CPU_IMEM_DEPTH; i++) begin
            @(posedge clk);
            #1;
            imem_we    = 1'b1;
            imem_addr  = i[`CPU_IMEM_AW-1:0];
            imem_wdata = (i < len) ? prog[start + i] : '0;
        end
        @(posedge clk);
        #1;
        imem_we = 1'b0;
    endtask

    task automatic check_idle();
        int errs_before;
        int i;
        errs_before = errors;
        reset_dut();
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            check_level("reset_idle", "dmem_re", 1'b0, dmem_re);
            check_level("reset_idle", "dmem_we", 1'b0, dmem_we);
            check_level("reset_idle", "halted", 1'b0, halted);
        end
        tests_run++;
        if (errors != errs_before)
            tests_failed++;
        $display("test reset_idle: %0d errors", errors - errs_before);
    endtask

    task automatic run_program(input string name, input int t, input logic with_miss);
        int errs_before;
        int i;
        errs_before = errors;
        @(negedge clk);
        rand_miss = with_miss;
        reset_dut();
        act_n = 0;
        for (i = 0; i < 256; i++)
            dmem[i] = fill_word(i);
        load_program(test_start[t], test_len[t]);
        ref_run(test_start[t], test_len[t]);
        @(posedge clk);
        #1;
        run = 1'b1;
        while (!halted)
            @(negedge clk);
        // frozen pipeline, nothing more may reach memory
        repeat (10) @(negedge clk);
        check_level(name, "halted", 1'b1, halted);
        if (act_n != exp_n) begin
            $display("MISMATCH %s store count: expected %0d actual %0d", name, exp_n, act_n);
            errors++;
        end
        for (i = 0; i < exp_n && i < act_n && i < 64; i++)
            check_store(name, i, exp_addr[i], exp_data[i], act_addr[i], act_data[i]);
        @(posedge clk);
        #1;
        run = 1'b0;
        tests_run++;
        if (errors != errs_before)
            tests_failed++;
        $display("test %s: %0d stores, %0d errors", name, act_n, errors - errs_before);
    endtask

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        run          = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        dmem_rdata   = '0;
        miss         = 1'b0;
        rand_miss    = 1'b0;
        rnd_state    = 32'h079a_ecfa;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        run_cycles   = 0;
        act_n        = 0;
        build_programs();
        // branch program runs twice
        cycle_limit = 40 * (test_len[0] + test_len[1] + 2 * test_len[2] + test_len[3]);

        check_idle();
        run_program("alu_chain", 0, 1'b0);
        run_program("load_use", 1, 1'b0);
        run_program("branch", 2, 1'b0);
        run_program("branch_miss", 2, 1'b1);
        run_program("r0_halt", 3, 1'b0);

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
verilog/cpu_pkg.sv
verilog/hazard_if.sv
verilog/fetch.sv
verilog/register_file.sv
verilog/decode.sv
verilog/exec.sv
verilog/memory.sv
verilog/hazard_unit.sv
verilog/cpu.sv
verification/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - include_dirs:
      - include
    files:
      - verilog/cpu_pkg.sv
      - verilog/hazard_if.sv
      - verilog/fetch.sv
      - verilog/register_file.sv
      - verilog/decode.sv
      - verilog/exec.sv
      - verilog/memory.sv
      - verilog/hazard_unit.sv
      - verilog/cpu.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/cpu_tb.sv
